// ==== serdes_pkg.sv ====
package serdes_pkg;

	// serial word geometry
	localparam int WORD_WIDTH = 8;
	localparam int PHASE_BITS = $clog2(WORD_WIDTH); // bit position within a word
	localparam logic [PHASE_BITS-1:0] LAST_PHASE = PHASE_BITS'(WORD_WIDTH - 1);

	// word layout in counting mode
	localparam int HEADER_BITS = 4;
	localparam int SEQ_BITS = WORD_WIDTH - HEADER_BITS;

	// line stays idle this many word periods after reset
	localparam int RESET_HOLD_WORDS = 16;
	localparam int HOLD_COUNT_BITS = $clog2(RESET_HOLD_WORDS);
	localparam logic [HOLD_COUNT_BITS-1:0] HOLD_LAST = HOLD_COUNT_BITS'(RESET_HOLD_WORDS - 1);

	// heartbeat toggles once per this many word periods
	localparam int HEARTBEAT_WORDS = 32;
	localparam int HEARTBEAT_COUNT_BITS = $clog2(HEARTBEAT_WORDS);
	localparam logic [HEARTBEAT_COUNT_BITS-1:0] HEARTBEAT_LAST =
		HEARTBEAT_COUNT_BITS'(HEARTBEAT_WORDS - 1);

	localparam logic [WORD_WIDTH-1:0] TRAINING_WORD = 8'hAC; // alternating-ish, easy to lock on

	// counting word as built by the pattern source
	typedef struct packed {
		logic [HEADER_BITS-1:0] header; // upper nibble, zero when counting
		logic [SEQ_BITS-1:0] seq; // lower nibble, wraps
	} serdes_fields_t;

	// same word seen as fields or as the bits that go on the line
	typedef union packed {
		logic [WORD_WIDTH-1:0] raw;
		serdes_fields_t fields;
	} serdes_word_u;

endpackage

// ==== word_pacer.sv ====
`timescale 1ns/1ps

module word_pacer (
	input  logic clock,
	input  logic reset,
	output logic word_strobe,
	output logic heartbeat
);

	logic [serdes_pkg::PHASE_BITS-1:0] phase; // bit position within current word
	logic [serdes_pkg::HEARTBEAT_COUNT_BITS-1:0] word_count;

	// free running, wraps once per word
	always_ff @(posedge clock) begin
		if (reset) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// one cycle per word period, stands in for the divided clock
	assign word_strobe = (phase == serdes_pkg::LAST_PHASE);

	// slow blink so a running design is visible
	always_ff @(posedge clock) begin
		if (reset) begin
			word_count <= '0;
			heartbeat <= 1'b0;
		end else if (word_strobe) begin
			if (word_count == serdes_pkg::HEARTBEAT_LAST) begin
				word_count <= '0;
				heartbeat <= !heartbeat;
			end else begin
				word_count <= word_count + 1'b1;
			end
		end
	end

	// downstream logic relies on a single cycle pulse per word
	strobe_single_cycle: assert property (
		@(posedge clock) disable iff (reset)
		word_strobe |=> !word_strobe
	) else $error("word_strobe high on consecutive cycles");

endmodule

// ==== reset_stretcher.sv ====
`timescale 1ns/1ps

module reset_stretcher (
	input  logic clock,
	input  logic reset,
	input  logic word_strobe,
	output logic line_ready,
	output logic hold_led
);

	logic [serdes_pkg::HOLD_COUNT_BITS-1:0] hold_count; // word periods seen so far

	// count strobes until the link has had time to settle
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_count <= '0;
			line_ready <= 1'b0;
		end else if (word_strobe && !line_ready) begin
			if (hold_count == serdes_pkg::HOLD_LAST) begin
				line_ready <= 1'b1; // sticky until next reset
			end else begin
				hold_count <= hold_count + 1'b1;
			end
		end
	end

	// lit while the line is held idle
	always_ff @(posedge clock) begin
		if (reset) begin
			hold_led <= 1'b1;
		end else begin
			hold_led <= !line_ready;
		end
	end

	// once released the line only goes back to idle through reset
	line_ready_sticky: assert property (
		@(posedge clock) line_ready && !reset |=> line_ready
	) else $error("line_ready dropped without reset");

endmodule

// ==== pattern_source.sv ====
`timescale 1ns/1ps

module pattern_source (
	input  logic clock,
	input  logic reset,
	input  logic word_strobe,
	input  logic line_ready,
	input  logic training,
	output serdes_pkg::serdes_word_u current_word
);

	logic [serdes_pkg::SEQ_BITS-1:0] seq; // sequence of the last counting word
	logic [serdes_pkg::SEQ_BITS-1:0] next_seq;
	logic word_taken;

	assign next_seq = seq + 1'b1; // wraps at 16
	assign word_taken = word_strobe && line_ready; // serializer loads current_word here

	// training is only looked at when a word is taken,
	// so a change shows up in the word after the one being loaded
	always_ff @(posedge clock) begin
		if (reset) begin
			seq <= '0;
			current_word.fields.header <= '0;
			current_word.fields.seq <= '0; // first word after the hold is sequence 0
		end else if (word_taken) begin
			if (training) begin
				current_word.raw <= serdes_pkg::TRAINING_WORD; // seq held for resume
			end else begin
				seq <= next_seq;
				current_word.fields.header <= '0;
				current_word.fields.seq <= next_seq;
			end
		end
	end

endmodule

// ==== word_serializer.sv ====
`timescale 1ns/1ps

module word_serializer (
	input  logic clock,
	input  logic reset,
	input  logic word_strobe,
	input  logic line_ready,
	input  serdes_pkg::serdes_word_u load_word,
	output logic serial_out,
	output logic frame_start
);

	logic [serdes_pkg::WORD_WIDTH-1:0] shift_q; // msb is on the line

	// load on the strobe, otherwise shift left with ones behind the data
	always_ff @(posedge clock) begin
		if (reset) begin
			shift_q <= '1; // idle line is high
		end else if (word_strobe) begin
			if (line_ready) begin
				shift_q <= load_word.raw;
			end else begin
				shift_q <= '1; // still holding, send idle
			end
		end else begin
			shift_q <= {shift_q[serdes_pkg::WORD_WIDTH-2:0], 1'b1};
		end
	end

	assign serial_out = shift_q[serdes_pkg::WORD_WIDTH-1];

	// marks the msb cycle of every real word
	always_ff @(posedge clock) begin
		if (reset) begin
			frame_start <= 1'b0;
		end else begin
			frame_start <= word_strobe && line_ready;
		end
	end

	frame_after_strobe: assert property (
		@(posedge clock) disable iff (reset)
		frame_start |-> $past(word_strobe)
	) else $error("frame_start without a preceding strobe");

endmodule

// ==== serdes_test_top.sv ====
`timescale 1ns/1ps

module serdes_test_top (
	input  logic clock,
	input  logic reset,
	input  logic training,
	output logic serial_out,
	output logic frame_start,
	output logic heartbeat,
	output logic hold_led
);

	logic word_strobe; // one cycle per word period
	logic line_ready; // hold time over
	serdes_pkg::serdes_word_u current_word;

	word_pacer i_word_pacer (
		.clock       (clock),
		.reset       (reset),
		.word_strobe (word_strobe),
		.heartbeat   (heartbeat)
	);

	reset_stretcher i_reset_stretcher (
		.clock       (clock),
		.reset       (reset),
		.word_strobe (word_strobe),
		.line_ready  (line_ready),
		.hold_led    (hold_led)
	);

	// next word is ready before each strobe
	pattern_source i_pattern_source (
		.clock        (clock),
		.reset        (reset),
		.word_strobe  (word_strobe),
		.line_ready   (line_ready),
		.training     (training),
		.current_word (current_word)
	);

	word_serializer i_word_serializer (
		.clock       (clock),
		.reset       (reset),
		.word_strobe (word_strobe),
		.line_ready  (line_ready),
		.load_word   (current_word),
		.serial_out  (serial_out),
		.frame_start (frame_start)
	);

endmodule

// ==== serdes_test_tb.sv ====
`timescale 1ns/1ps

module serdes_test_tb;

	localparam int WORD_WIDTH = serdes_pkg::WORD_WIDTH;
	localparam int RESET_CYCLES = 3;
	// 16 strobes to release the line, the 17th loads word 0, frame_start one edge later
	localparam int HOLD_FRAME_CYCLES = (serdes_pkg::RESET_HOLD_WORDS + 1) * WORD_WIDTH;
	localparam int HEARTBEAT_CYCLES = serdes_pkg::HEARTBEAT_WORDS * WORD_WIDTH;
	localparam int MAX_TRAIN_FRAMES = 12;
	localparam int RESUME_FRAMES = 4;
	// framing, counting, two training bursts, heartbeat, counting after second reset
	localparam int TEST_FRAMES = 4 + 20 + 2 * (MAX_TRAIN_FRAMES + RESUME_FRAMES)
		+ 2 * serdes_pkg::HEARTBEAT_WORDS + 20;
	localparam int TIMEOUT_CYCLES =
		2 * (2 * (RESET_CYCLES + 1 + HOLD_FRAME_CYCLES) + TEST_FRAMES * WORD_WIDTH);

	logic clock;
	logic reset;
	logic training;
	logic serial_out;
	logic frame_start;
	logic heartbeat;
	logic hold_led;

	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int test_start_errors = 0;
	int cycle_count = 0;
	int since_reset; // edges since release, as sampled
	int since_frame;
	logic seen_frame;
	logic hb_prev;

	// expected words, built from the strobe timing and the training rule
	int model_strobes;
	logic [3:0] model_seq;
	logic [WORD_WIDTH-1:0] model_word;
	logic model_train;
	logic [WORD_WIDTH-1:0] loaded_word;
	logic loaded_train;

	// frame capture
	logic [WORD_WIDTH-1:0] shreg;
	int capture_bits;
	logic word_done;
	logic [WORD_WIDTH-1:0] captured_word;
	logic [WORD_WIDTH-1:0] expected_word;
	logic expected_training;

	serdes_test_top i_serdes_test_top (
		.clock       (clock),
		.reset       (reset),
		.training    (training),
		.serial_out  (serial_out),
		.frame_start (frame_start),
		.heartbeat   (heartbeat),
		.hold_led    (hold_led)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = !clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(posedge clock) begin
		if (reset) begin
			since_reset <= 0;
			since_frame <= 0;
			seen_frame <= 1'b0;
			hb_prev <= 1'b0;
		end else begin
			since_reset <= since_reset + 1;
			since_frame <= frame_start ? 0 : since_frame + 1;
			if (frame_start)
				seen_frame <= 1'b1;
			hb_prev <= heartbeat;
		end
	end

	// strobe on every 8th edge after release, words taken once the hold is over
	always @(posedge clock) begin
		if (reset) begin
			model_strobes <= 0;
			model_seq <= '0;
			model_word <= '0;
			model_train <= 1'b0;
			loaded_word <= '1;
			loaded_train <= 1'b0;
		end else if (since_reset % WORD_WIDTH == WORD_WIDTH - 1) begin
			if (model_strobes >= serdes_pkg::RESET_HOLD_WORDS) begin
				loaded_word <= model_word;
				loaded_train <= model_train;
				if (training) begin
					model_word <= serdes_pkg::TRAINING_WORD; // sequence held
					model_train <= 1'b1;
				end else begin
					model_seq <= model_seq + 1'b1;
					model_word <= {4'h0, model_seq + 1'b1};
					model_train <= 1'b0;
				end
			end else begin
				model_strobes <= model_strobes + 1;
			end
		end
	end

	// msb sampled together with frame_start, then 7 more bits
	always @(posedge clock) begin
		if (reset) begin
			capture_bits <= 0;
			word_done <= 1'b0;
		end else begin
			word_done <= 1'b0;
			if (frame_start) begin
				shreg <= {shreg[WORD_WIDTH-2:0], serial_out};
				capture_bits <= 1;
			end else if (capture_bits != 0) begin
				shreg <= {shreg[WORD_WIDTH-2:0], serial_out};
				if (capture_bits == WORD_WIDTH - 1) begin
					word_done <= 1'b1;
					captured_word <= {shreg[WORD_WIDTH-2:0], serial_out};
					expected_word <= loaded_word;
					expected_training <= loaded_train;
					capture_bits <= 0;
				end else begin
					capture_bits <= capture_bits + 1;
				end
			end
		end
	end

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t: %s", $time, msg);
		error_count++;
	endtask

	hold_idle: assert property (@(posedge clock) disable iff (reset)
		hold_led |-> serial_out && !frame_start)
		else report_mismatch("line not idle during hold");
	hold_early: assert property (@(posedge clock) disable iff (reset)
		since_reset < serdes_pkg::RESET_HOLD_WORDS * WORD_WIDTH |-> hold_led)
		else report_mismatch("hold_led low before hold time");
	hold_released: assert property (@(posedge clock) disable iff (reset)
		since_reset >= HOLD_FRAME_CYCLES |-> !hold_led)
		else report_mismatch("hold_led still high after hold time");
	first_frame_time: assert property (@(posedge clock) disable iff (reset)
		frame_start && !seen_frame |-> since_reset == HOLD_FRAME_CYCLES)
		else report_mismatch("first frame_start at wrong cycle");
	frame_spacing: assert property (@(posedge clock) disable iff (reset)
		seen_frame |-> frame_start == (since_frame == WORD_WIDTH - 1))
		else report_mismatch("frame_start spacing not 8 cycles");
	word_value: assert property (@(posedge clock) disable iff (reset)
		word_done |-> captured_word == expected_word)
		else report_mismatch($sformatf("word %02h expected %02h", captured_word, expected_word));
	count_header: assert property (@(posedge clock) disable iff (reset)
		word_done && !expected_training |-> captured_word[WORD_WIDTH-1:4] == 4'h0)
		else report_mismatch("counting word with nonzero header");
	heartbeat_period: assert property (@(posedge clock) disable iff (reset)
		since_reset > 0 |-> (heartbeat != hb_prev) == (since_reset % HEARTBEAT_CYCLES == 0))
		else report_mismatch("heartbeat toggled off its period");

	task automatic apply_reset;
		@(posedge clock);
		#1 reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;
	endtask

	task automatic wait_frames(input int count);
		for (int i = 0; i < count; i++) begin
			do @(posedge clock); while (!frame_start);
		end
	endtask

	task automatic end_test(input string name);
		int new_errors;
		new_errors = error_count - test_start_errors;
		test_count++;
		if (new_errors != 0)
			failed_tests++;
		$display("test %0d %s finished with %0d errors", test_count, name, new_errors);
		test_start_errors = error_count;
	endtask

	initial begin
		int train_frames;
		reset = 1'b1;
		training = 1'b0;
		void'($urandom(32'hb427_7e6d));
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b0;

		wait_frames(1); // hold checks run until the first frame
		end_test("reset_hold");

		wait_frames(4);
		end_test("framing");

		wait_frames(20); // covers a wrap of the sequence
		end_test("counting");

		for (int burst = 0; burst < 2; burst++) begin
			train_frames = 5 + ($urandom % 8);
			#1 training = 1'b1;
			wait_frames(train_frames);
			#1 training = 1'b0;
			wait_frames(RESUME_FRAMES);
		end
		end_test("training");

		wait_frames(2 * serdes_pkg::HEARTBEAT_WORDS);
		end_test("heartbeat");

		repeat (3) @(posedge clock); // land mid frame
		apply_reset();
		wait_frames(18);
		repeat (WORD_WIDTH + 2) @(posedge clock);
		end_test("reset_mid_run");

		$display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== serdes_test_top.f ====
serdes_pkg.sv
word_pacer.sv
reset_stretcher.sv
pattern_source.sv
word_serializer.sv
serdes_test_top.sv
serdes_test_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the serializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f serdes_test_top.f --top-module serdes_test_tb \
	-o serdes_test_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/serdes_test_sim > sim.log 2>&1
cat sim.log

grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
